//--- Bender.yml
package:
  name: fabric

sources:
  - fabric_pkg.sv
  - clb_func_gen.sv
  - clb.sv
  - cfg_wb_regs.sv
  - clb_input_route.sv
  - fabric_top.sv
  - target: test
    files:
      - fabric_chk.sv
      - fabric_tb.sv

//--- all.f
fabric_pkg.sv
clb_func_gen.sv
clb.sv
cfg_wb_regs.sv
clb_input_route.sv
fabric_top.sv
fabric_chk.sv
fabric_tb.sv

//--- cfg_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_wb_regs
   import fabric_pkg::*;
(
   input  logic             KLK,
   input  logic             arst_n,
   input  logic             wb_cyc,
   input  logic             wb_stb,
   input  logic             wb_we,
   input  logic [WB_AW-1:0] wb_adr,
   input  cfg_word_t        wb_dat_w,
   output cfg_word_t        wb_dat_r,
   output logic             wb_ack,
   output cfg_word_t        clb_cfg [2*NUM_CLB],
   output cfg_word_t        pad_cfg
);

   cfg_word_t cfg_mem [NUM_CFG_WORDS];
   logic      req;      // new request, not yet acked
   logic      adr_ok;

   assign req    = wb_cyc & wb_stb & ~wb_ack;
   assign adr_ok = (wb_adr < WB_AW'(NUM_CFG_WORDS));

   ///////////////////////////////////////////////////////////////////////
   // handshake, one cycle from request to ack
   ///////////////////////////////////////////////////////////////////////
   always_ff @(posedge KLK or negedge arst_n)
   begin
      if (!arst_n)
         wb_ack <= 1'b0;
      else
         wb_ack <= req;
   end

   // write lands on the edge that raises ack
   always_ff @(posedge KLK or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int w = 0; w < NUM_CFG_WORDS; w++)
            cfg_mem[w] <= '0;
      end
      else if (req && wb_we && adr_ok)
      begin
         cfg_mem[wb_adr] <= wb_dat_w;
      end
   end

   // master holds adr through ack, so read data can come straight from it
   assign wb_dat_r = adr_ok ? cfg_mem[wb_adr] : '0;

   ///////////////////////////////////////////////////////////////////////
   // configuration out to the fabric
   ///////////////////////////////////////////////////////////////////////
   for (genvar w = 0; w < 2 * NUM_CLB; w++)
   begin : g_clb_cfg
      assign clb_cfg[w] = cfg_mem[w];
   end

   assign pad_cfg = cfg_mem[PAD_CFG_ADDR];

endmodule

`default_nettype wire

//--- clb.sv
`timescale 1ns/1ps
`default_nettype none

module clb
   import fabric_pkg::*;
(
   input  logic      KLK,
   input  logic      arst_n,
   input  logic      a,
   input  logic      b,
   input  logic      c,
   input  logic      d,
   input  logic      k,
   input  cfg_word_t logic_cfg,
   input  cfg_word_t out_cfg,
   output logic      x,
   output logic      y,
   output logic      q
);

   lut_mem_t         lut;
   sel2_t            mode;
   logic [O2M_W-1:0] o2m;
   logic             dq1_sel;
   logic             dq2_sel;
   sel2_t            set_sel;
   sel2_t            rst_sel;
   sel2_t            en_sel;
   sel2_t            x_sel;
   sel2_t            y_sel;

   logic             dq1;
   logic             dq2;
   logic             f;
   logic             g;
   logic             s;
   logic             r;
   logic             en;
   logic             q_r;

   ///////////////////////////////////////////////////////////////////////
   // field split
   ///////////////////////////////////////////////////////////////////////
   assign lut     = logic_cfg[LUT_LSB +: $bits(lut_mem_t)];
   assign mode    = logic_cfg[MODE_LSB +: 2];
   assign o2m     = logic_cfg[O2M_LSB +: O2M_W];
   assign dq1_sel = logic_cfg[DQ_LSB];
   assign dq2_sel = logic_cfg[DQ_LSB + 1];
   assign set_sel = logic_cfg[SET_LSB +: 2];
   assign rst_sel = logic_cfg[RST_LSB +: 2];
   assign en_sel  = logic_cfg[EN_LSB +: 2];
   assign x_sel   = out_cfg[XSEL_LSB +: 2];
   assign y_sel   = out_cfg[YSEL_LSB +: 2];

   // feedback from the storage element
   assign dq1 = dq1_sel ? q_r : d;
   assign dq2 = dq2_sel ? q_r : d;

   clb_func_gen u_func_gen (
      .a    (a),
      .b    (b),
      .c    (c),
      .dq1  (dq1),
      .dq2  (dq2),
      .lut  (lut),
      .mode (mode),
      .o2m  (o2m),
      .f    (f),
      .g    (g)
   );

   assign s  = (set_sel == 2'd0) ? a : ((set_sel == 2'd1) ? f : 1'b0);
   assign r  = (rst_sel == 2'd0) ? d : ((rst_sel == 2'd1) ? g : 1'b0);
   assign en = (en_sel == 2'd0)  ? g : ((en_sel == 2'd1)  ? c : k);

   ///////////////////////////////////////////////////////////////////////
   // storage element, reset beats set
   ///////////////////////////////////////////////////////////////////////
   always_ff @(posedge KLK or negedge arst_n)
   begin
      if (!arst_n)
         q_r <= 1'b0;
      else if (en)
      begin
         if (r)
            q_r <= 1'b0;
         else if (s)
            q_r <= 1'b1;
         else
            q_r <= f;
      end
   end

   assign x = (x_sel == 2'd0) ? f   : ((x_sel == 2'd1) ? g : q_r);
   assign y = (y_sel == 2'd0) ? q_r : ((y_sel == 2'd1) ? g : f);
   assign q = q_r;

endmodule

`default_nettype wire

//--- clb_func_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clb_func_gen
   import fabric_pkg::*;
(
   input  logic             a,
   input  logic             b,
   input  logic             c,
   input  logic             dq1,
   input  logic             dq2,
   input  lut_mem_t         lut,
   input  sel2_t            mode,
   input  logic [O2M_W-1:0] o2m,
   output logic             f,
   output logic             g
);

   logic [3:0] idx4;     // one 4-input function
   logic [2:0] idx_f3;   // low half in split mode
   logic [2:0] idx_g3;   // high half in split mode
   logic [3:0] idx5;     // b picks the half
   logic       lut4_out;
   logic       lut5_out;

   assign idx4 = {a, b, c, dq1};

   ///////////////////////////////////////////////////////////////////////
   // input muxes for the two 3-input functions
   ///////////////////////////////////////////////////////////////////////
   assign idx_f3[2] = o2m[0] ? b   : a;
   assign idx_f3[1] = o2m[1] ? c   : b;
   assign idx_f3[0] = o2m[2] ? dq1 : c;

   assign idx_g3[2] = o2m[3] ? b   : a;
   assign idx_g3[1] = o2m[4] ? c   : b;
   assign idx_g3[0] = o2m[5] ? dq2 : c;

   // 5-input form, b is the top address bit
   assign idx5 = b ? {1'b1, a, c, dq2} : {1'b0, a, c, dq1};

   assign lut4_out = lut[idx4];
   assign lut5_out = lut[idx5];

   always_comb
   begin
      case (mode)
         MODE_LUT4:
         begin
            f = lut4_out;
            g = lut4_out;
         end
         MODE_LUT3X2:
         begin
            f = lut[{1'b0, idx_f3}];
            g = lut[{1'b1, idx_g3}];
         end
         default:   // modes 2 and 3 behave the same
         begin
            f = lut5_out;
            g = lut5_out;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- clb_input_route.sv
`timescale 1ns/1ps
`default_nettype none

module clb_input_route
   import fabric_pkg::*;
(
   input  logic [NUM_PAD_IN-1:0]  pad_in,
   input  logic [NUM_CLB-1:0]     clb_x,
   input  logic [NUM_CLB-1:0]     clb_y,
   input  cfg_word_t              route_cfg [NUM_CLB],
   input  cfg_word_t              pad_cfg,
   output logic [NUM_CLB-1:0]     clb_a,
   output logic [NUM_CLB-1:0]     clb_b,
   output logic [NUM_CLB-1:0]     clb_c,
   output logic [NUM_CLB-1:0]     clb_d,
   output logic [NUM_CLB-1:0]     clb_k,
   output logic [NUM_PAD_OUT-1:0] pad_out
);

   logic [2*NUM_CLB-1:0] out_src;   // x outputs low, y outputs high

   ///////////////////////////////////////////////////////////////////////
   // clb inputs, feed-forward only
   ///////////////////////////////////////////////////////////////////////
   for (genvar i = 0; i < NUM_CLB; i++)
   begin : g_clb
      // only clbs below i are visible, the rest read 0
      localparam logic [NUM_CLB-1:0] LOWER_MASK = NUM_CLB'((1 << i) - 1);

      logic [NUM_SRC-1:0]    src;
      logic [NUM_CLB_IN-1:0] ins;

      assign src = {clb_x & LOWER_MASK, pad_in};

      always_comb
      begin
         for (int j = 0; j < NUM_CLB_IN; j++)
            ins[j] = src[src_sel_t'(route_cfg[i][ROUTE_LSB + ROUTE_W*j +: ROUTE_W])];
      end

      assign clb_a[i] = ins[0];
      assign clb_b[i] = ins[1];
      assign clb_c[i] = ins[2];
      assign clb_d[i] = ins[3];
      assign clb_k[i] = ins[4];
   end

   ///////////////////////////////////////////////////////////////////////
   // output pads
   ///////////////////////////////////////////////////////////////////////
   assign out_src = {clb_y, clb_x};

   always_comb
   begin
      for (int p = 0; p < NUM_PAD_OUT; p++)
         pad_out[p] = out_src[src_sel_t'(pad_cfg[PAD_SEL_LSB + ROUTE_W*p +: ROUTE_W])];
   end

endmodule

`default_nettype wire

//--- fabric_chk.sv
`timescale 1ns/1ps
`default_nettype none

module fabric_chk
(
   input logic KLK,
   input logic arst_n,
   input logic wb_cyc,
   input logic wb_stb,
   input logic wb_ack
);

   int n_fail = 0;   // failed assertions so far

   // ack is a single pulse
   ack_one_cycle: assert property (@(posedge KLK) disable iff (!arst_n)
      wb_ack |=> !wb_ack)
      else
      begin
         n_fail++;
         $error("wb_ack stayed high for more than one cycle");
      end

   ack_after_req: assert property (@(posedge KLK) disable iff (!arst_n)
      (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
      else
      begin
         n_fail++;
         $error("sampled request not acknowledged on the next cycle");
      end

   ack_has_req: assert property (@(posedge KLK) disable iff (!arst_n)
      wb_ack |-> $past(wb_cyc && wb_stb && !wb_ack))
      else
      begin
         n_fail++;
         $error("wb_ack raised without a sampled request");
      end

   ack_in_reset: assert property (@(posedge KLK) !arst_n |-> !wb_ack)
      else
      begin
         n_fail++;
         $error("wb_ack high during reset");
      end

endmodule

bind cfg_wb_regs fabric_chk u_chk (
   .KLK    (KLK),
   .arst_n (arst_n),
   .wb_cyc (wb_cyc),
   .wb_stb (wb_stb),
   .wb_ack (wb_ack)
);

`default_nettype wire

//--- fabric_pkg.sv
`default_nettype none

package fabric_pkg;

   ///////////////////////////////////////////////////////////////////////
   // fabric size
   ///////////////////////////////////////////////////////////////////////
   localparam int NUM_CLB       = 4;
   localparam int NUM_PAD_IN    = 4;
   localparam int NUM_PAD_OUT   = 2;
   localparam int NUM_SRC       = NUM_PAD_IN + NUM_CLB;   // pads first, then clb x
   localparam int NUM_CLB_IN    = 5;                      // a, b, c, d, k

   // bus
   localparam int WB_DW         = 32;
   localparam int WB_AW         = 4;
   localparam int NUM_CFG_WORDS = 2 * NUM_CLB + 1;
   localparam int PAD_CFG_ADDR  = 2 * NUM_CLB;

   typedef logic [WB_DW-1:0] cfg_word_t;
   typedef logic [15:0]      lut_mem_t;
   typedef logic [1:0]       sel2_t;
   typedef logic [2:0]       src_sel_t;

   ///////////////////////////////////////////////////////////////////////
   // logic word 2i, lowest bit of each field
   ///////////////////////////////////////////////////////////////////////
   localparam int LUT_LSB  = 0;    // function memory, 16 bits
   localparam int MODE_LSB = 16;
   localparam int O2M_LSB  = 18;   // o2m1_0 at 18 up to o2m3_1 at 23
   localparam int O2M_W    = 6;
   localparam int DQ_LSB   = 24;   // dq1 select, dq2 select above it
   localparam int SET_LSB  = 26;
   localparam int RST_LSB  = 28;
   localparam int EN_LSB   = 30;

   // output and route word 2i+1
   localparam int XSEL_LSB  = 0;
   localparam int YSEL_LSB  = 2;
   localparam int ROUTE_LSB = 4;   // a, b, c, d, k in rising order
   localparam int ROUTE_W   = $bits(src_sel_t);

   // pad word, index 0..3 is clb x, 4..7 is clb y
   localparam int PAD_SEL_LSB = 0;

   // function generator modes
   localparam sel2_t MODE_LUT4   = 2'd0;
   localparam sel2_t MODE_LUT3X2 = 2'd1;

endpackage

`default_nettype wire

//--- fabric_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fabric_tb
   import fabric_pkg::*;
();

   localparam int N_RAND      = 48;    // random pad patterns per test
   localparam int N_ACCESS    = 50;    // bus accesses over all tests
   localparam int BUS_CYC     = 3;
   localparam int TIMEOUT_CYC = 2 + N_ACCESS*BUS_CYC + 2*16 + 3*N_RAND + 6 + 200;

   logic                   KLK;
   logic                   arst_n;
   logic                   wb_cyc;
   logic                   wb_stb;
   logic                   wb_we;
   logic [WB_AW-1:0]       wb_adr;
   cfg_word_t              wb_dat_w;
   logic [WB_DW/8-1:0]     wb_sel;
   cfg_word_t              wb_dat_r;
   logic                   wb_ack;
   logic [NUM_PAD_IN-1:0]  pad_in;
   logic [NUM_PAD_OUT-1:0] pad_out;

   cfg_word_t          shadow [NUM_CFG_WORDS];   // words as written by the testbench
   logic [NUM_CLB-1:0] mq;                       // model storage state
   logic               cmp_en;
   logic [31:0]        lfsr_state = 32'h75d2_6a5a;
   int                 n_err = 0;
   int                 n_checks = 0;
   int                 n_tests = 0;

   fabric_top UUT (
      .KLK      (KLK),
      .arst_n   (arst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_sel   (wb_sel),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .pad_in   (pad_in),
      .pad_out  (pad_out)
   );

   initial
   begin
      KLK = 1'b0;
      forever #5 KLK = ~KLK;
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v = {v[30:0], lfsr_state[31]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return v;
   endfunction

   function automatic logic pick3(input sel2_t sel, input logic v0, v1, v2);
      return (sel == 2'd0) ? v0 : ((sel == 2'd1) ? v1 : v2);
   endfunction

   function automatic cfg_word_t logic_word(input lut_mem_t lut, input sel2_t mode,
                                            input logic [5:0] o2m, input logic [1:0] dq,
                                            input sel2_t set_s, rst_s, en_s);
      cfg_word_t w;
      w = '0;
      w[LUT_LSB +: 16]    = lut;
      w[MODE_LSB +: 2]    = mode;
      w[O2M_LSB +: O2M_W] = o2m;
      w[DQ_LSB +: 2]      = dq;
      w[SET_LSB +: 2]     = set_s;
      w[RST_LSB +: 2]     = rst_s;
      w[EN_LSB +: 2]      = en_s;
      return w;
   endfunction

   // sources 0..3 are pads, 4..7 are clb x outputs
   function automatic cfg_word_t route_word(input sel2_t xs, ys,
                                            input src_sel_t a, b, c, d, k);
      cfg_word_t w;
      w = '0;
      w[XSEL_LSB +: 2] = xs;
      w[YSEL_LSB +: 2] = ys;
      w[ROUTE_LSB +: 4*ROUTE_W] = {d, c, b, a};
      w[ROUTE_LSB + 4*ROUTE_W +: ROUTE_W] = k;
      return w;
   endfunction

   function automatic cfg_word_t pad_word(input src_sel_t p0, p1);
      cfg_word_t w;
      w = '0;
      w[PAD_SEL_LSB +: 2*ROUTE_W] = {p1, p0};
      return w;
   endfunction

   ////////////////////////////////////////////////////////////////////////
   // reference model, returns {next q, pad_out}
   ////////////////////////////////////////////////////////////////////////
   function automatic logic [5:0] fabric_model(input logic [3:0] pads, input logic [3:0] qs);
      logic [3:0] xs, ys, qn;
      logic [4:0] ins;    // a b c d k
      logic [1:0] po;
      cfg_word_t  lw, ow;
      lut_mem_t   lut;
      logic       f, g, s, r, en, dq1, dq2;
      int         sel;
      xs = '0;
      ys = '0;
      for (int i = 0; i < NUM_CLB; i++)
      begin
         lw  = shadow[2*i];
         ow  = shadow[2*i+1];
         lut = lw[LUT_LSB +: 16];
         for (int j = 0; j < NUM_CLB_IN; j++)
         begin
            sel = ow[ROUTE_LSB + ROUTE_W*j +: ROUTE_W];
            if (sel < NUM_PAD_IN)
               ins[j] = pads[sel];
            else if (sel - NUM_PAD_IN < i)
               ins[j] = xs[sel-NUM_PAD_IN];
            else
               ins[j] = 1'b0;    // itself or a later clb
         end
         dq1 = lw[DQ_LSB] ? qs[i] : ins[3];
         dq2 = lw[DQ_LSB+1] ? qs[i] : ins[3];
         case (lw[MODE_LSB +: 2])
            2'd0: f = lut[{ins[0], ins[1], ins[2], dq1}];
            2'd1: f = lut[{1'b0, lw[O2M_LSB] ? ins[1] : ins[0],
                           lw[O2M_LSB+1] ? ins[2] : ins[1], lw[O2M_LSB+2] ? dq1 : ins[2]}];
            default: f = ins[1] ? lut[{1'b1, ins[0], ins[2], dq2}]
                                : lut[{1'b0, ins[0], ins[2], dq1}];
         endcase
         g = f;
         if (lw[MODE_LSB +: 2] == 2'd1)
            g = lut[{1'b1, lw[O2M_LSB+3] ? ins[1] : ins[0],
                     lw[O2M_LSB+4] ? ins[2] : ins[1], lw[O2M_LSB+5] ? dq2 : ins[2]}];
         s  = pick3(lw[SET_LSB +: 2], ins[0], f, 1'b0);
         r  = pick3(lw[RST_LSB +: 2], ins[3], g, 1'b0);
         en = pick3(lw[EN_LSB +: 2], g, ins[2], ins[4]);
         qn[i] = !en ? qs[i] : (r ? 1'b0 : (s ? 1'b1 : f));
         xs[i] = pick3(ow[XSEL_LSB +: 2], f, g, qs[i]);
         ys[i] = pick3(ow[YSEL_LSB +: 2], qs[i], g, f);
      end
      for (int p = 0; p < NUM_PAD_OUT; p++)
      begin
         sel = shadow[PAD_CFG_ADDR][PAD_SEL_LSB + ROUTE_W*p +: ROUTE_W];
         po[p] = (sel < NUM_CLB) ? xs[sel] : ys[sel-NUM_CLB];
      end
      return {qn, po};
   endfunction

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      n_checks++;
      if (got !== exp)
      begin
         n_err++;
         $display("[ERROR] %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic test_done(input int num, input string name, input int err_before);
      n_tests++;
      $display("test %0d %s: %0d errors", num, name, n_err - err_before);
   endtask

   task automatic wb_write(input logic [WB_AW-1:0] adr, input cfg_word_t dat);
      @(negedge KLK);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= 1'b1;
      wb_adr   <= adr;
      wb_dat_w <= dat;
      do @(negedge KLK); while (wb_ack !== 1'b1);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      if (adr < NUM_CFG_WORDS)
         shadow[adr] <= dat;    // in step with the fabric from the next edge on
   endtask

   task automatic wb_read(input logic [WB_AW-1:0] adr, output cfg_word_t dat);
      @(negedge KLK);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we  <= 1'b0;
      wb_adr <= adr;
      do @(negedge KLK); while (wb_ack !== 1'b1);
      dat = wb_dat_r;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
   endtask

   task automatic run_pads(input int n, input logic sweep);
      for (int i = 0; i < n; i++)
      begin
         @(negedge KLK);
         cmp_en <= 1'b1;
         pad_in <= sweep ? NUM_PAD_IN'(i) : NUM_PAD_IN'(rand_bits(NUM_PAD_IN));
      end
      @(negedge KLK);    // last pattern still compared here
      cmp_en <= 1'b0;
   endtask

   always @(posedge KLK or negedge arst_n)
   begin : model_q
      logic [5:0] res;
      if (!arst_n)
         mq <= '0;
      else
      begin
         res = fabric_model(pad_in, mq);
         mq <= res[5:2];
      end
   end

   // outputs have been stable since the rising edge
   always @(negedge KLK)
   begin : compare
      logic [5:0] res;
      if (cmp_en)
      begin
         res = fabric_model(pad_in, mq);
         check(pad_out, res[1:0], $sformatf("pad_out for pads %b", pad_in));
         check(UUT.clb_q, mq, "storage state of all clbs");
      end
   end

   initial
   begin
      repeat (TIMEOUT_CYC) @(posedge KLK);
      $display("timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYC);
      $display("SIMULATION FAILED");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////////////////
   initial
   begin : main
      cfg_word_t rd;
      int        e0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      wb_sel   = '1;
      pad_in   = '0;
      cmp_en   = 1'b0;
      arst_n   = 1'b0;
      for (int w = 0; w < NUM_CFG_WORDS; w++)
         shadow[w] = '0;
      repeat (2) @(posedge KLK);
      @(negedge KLK);
      arst_n <= 1'b1;

      e0 = n_err;
      for (int w = 0; w < NUM_CFG_WORDS; w++)
      begin
         wb_read(WB_AW'(w), rd);
         check(rd, '0, $sformatf("reset value of word %0d", w));
      end
      check(32'(pad_out), '0, "pad_out after reset");
      for (int w = 0; w <= NUM_CFG_WORDS; w++)
         wb_write(WB_AW'(w), rand_bits(32));
      for (int w = 0; w <= NUM_CFG_WORDS; w++)
      begin
         wb_read(WB_AW'(w), rd);
         check(rd, (w < NUM_CFG_WORDS) ? shadow[w] : '0, $sformatf("readback of word %0d", w));
      end
      test_done(1, "register reset and readback", e0);

      e0 = n_err;
      wb_write(0, logic_word(rand_bits(16), 2'd0, '0, 2'b00, 2'd2, 2'd2, 2'd2));
      wb_write(1, route_word(2'd0, 2'd0, 3'd3, 3'd2, 3'd1, 3'd0, 3'd0));
      wb_write(PAD_CFG_ADDR, pad_word(3'd0, 3'd4));
      run_pads(16, 1'b1);
      test_done(2, "mode 0 function memory", e0);

      e0 = n_err;
      wb_write(0, logic_word(rand_bits(16), 2'd1, rand_bits(6), 2'b00, 2'd2, 2'd2, 2'd2));
      wb_write(1, route_word(2'd0, 2'd1, 3'd3, 3'd2, 3'd1, 3'd0, 3'd0));
      wb_write(PAD_CFG_ADDR, pad_word(3'd0, 3'd4));
      run_pads(N_RAND, 1'b0);
      test_done(3, "mode 1 split functions", e0);

      e0 = n_err;
      wb_write(0, logic_word(rand_bits(16), 2'd2, '0, 2'b00, 2'd2, 2'd2, 2'd2));
      wb_write(1, route_word(2'd0, 2'd1, 3'd3, 3'd2, 3'd1, 3'd0, 3'd0));
      wb_write(PAD_CFG_ADDR, pad_word(3'd0, 3'd4));
      run_pads(16, 1'b1);
      test_done(4, "mode 2 five-input form", e0);

      // set from a, reset from d, enable from k on pad 0
      e0 = n_err;
      wb_write(0, logic_word(rand_bits(16), 2'd0, '0, rand_bits(2), 2'd0, 2'd0, 2'd2));
      wb_write(1, route_word(2'd2, 2'd1, 3'd3, 3'd2, 3'd2, 3'd1, 3'd0));
      wb_write(PAD_CFG_ADDR, pad_word(3'd0, 3'd4));
      run_pads(N_RAND, 1'b0);
      test_done(5, "storage element", e0);

      e0 = n_err;
      for (int i = 0; i < NUM_CLB; i++)
         wb_write(WB_AW'(2*i), logic_word(rand_bits(16), 2'd0, '0, 2'b00, 2'd2, 2'd2, 2'd2));
      wb_write(1, route_word(2'd0, 2'd0, 3'd3, 3'd2, 3'd1, 3'd0, 3'd0));
      wb_write(3, route_word(2'd0, 2'd0, 3'd4, 3'd1, 3'd2, 3'd5, 3'd0));  // d is clb1 itself
      wb_write(5, route_word(2'd0, 2'd0, 3'd5, 3'd4, 3'd0, 3'd7, 3'd0));  // d is clb3
      wb_write(7, route_word(2'd0, 2'd0, 3'd6, 3'd5, 3'd4, 3'd3, 3'd0));
      wb_write(PAD_CFG_ADDR, pad_word(3'd3, 3'd2));
      run_pads(N_RAND, 1'b0);
      test_done(6, "routing chain", e0);

      $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
               n_tests, n_checks, n_err, UUT.u_cfg.u_chk.n_fail);
      if (n_err == 0 && UUT.u_cfg.u_chk.n_fail == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- fabric_top.sv
`timescale 1ns/1ps
`default_nettype none

module fabric_top
   import fabric_pkg::*;
(
   input  logic                   KLK,
   input  logic                   arst_n,
   input  logic                   wb_cyc,
   input  logic                   wb_stb,
   input  logic                   wb_we,
   input  logic [WB_AW-1:0]       wb_adr,
   input  cfg_word_t              wb_dat_w,
   input  logic [WB_DW/8-1:0]     wb_sel,     // full words only
   output cfg_word_t              wb_dat_r,
   output logic                   wb_ack,
   input  logic [NUM_PAD_IN-1:0]  pad_in,
   output logic [NUM_PAD_OUT-1:0] pad_out
);

   cfg_word_t            clb_cfg [2*NUM_CLB];
   cfg_word_t            route_cfg [NUM_CLB];
   cfg_word_t            pad_cfg;
   logic [NUM_CLB-1:0]   clb_a;
   logic [NUM_CLB-1:0]   clb_b;
   logic [NUM_CLB-1:0]   clb_c;
   logic [NUM_CLB-1:0]   clb_d;
   logic [NUM_CLB-1:0]   clb_k;
   logic [NUM_CLB-1:0]   clb_x;
   logic [NUM_CLB-1:0]   clb_y;
   logic [NUM_CLB-1:0]   clb_q;      // storage state, probed from outside

   cfg_wb_regs u_cfg (
      .KLK      (KLK),
      .arst_n   (arst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .clb_cfg  (clb_cfg),
      .pad_cfg  (pad_cfg)
   );

   clb_input_route u_route (
      .pad_in    (pad_in),
      .clb_x     (clb_x),
      .clb_y     (clb_y),
      .route_cfg (route_cfg),
      .pad_cfg   (pad_cfg),
      .clb_a     (clb_a),
      .clb_b     (clb_b),
      .clb_c     (clb_c),
      .clb_d     (clb_d),
      .clb_k     (clb_k),
      .pad_out   (pad_out)
   );

   for (genvar i = 0; i < NUM_CLB; i++)
   begin : g_clb
      assign route_cfg[i] = clb_cfg[2*i+1];

      clb u_clb (
         .KLK       (KLK),
         .arst_n    (arst_n),
         .a         (clb_a[i]),
         .b         (clb_b[i]),
         .c         (clb_c[i]),
         .d         (clb_d[i]),
         .k         (clb_k[i]),
         .logic_cfg (clb_cfg[2*i]),
         .out_cfg   (clb_cfg[2*i+1]),
         .x         (clb_x[i]),
         .y         (clb_y[i]),
         .q         (clb_q[i])
      );
   end

endmodule

`default_nettype wire
